/* hw/msr_map_pkg.sv */
package msr_map_pkg;

   localparam int MSR_BANK_W = 3;
   localparam int msr_off_w  = 9;

   // Bank code taken from address bits 11:9
   typedef enum logic [MSR_BANK_W-1:0] {
      BANK_PS   = 3'd0,
      BANK_IMM  = 3'd1,
      BANK_DMM  = 3'd2,
      BANK_ICA  = 3'd3,
      BANK_DCA  = 3'd4,
      BANK_DBG  = 3'd5,
      BANK_IRQC = 3'd6,
      BANK_TSC  = 3'd7
   } msr_bank_t;

   // PS bank, one offset bit per register
   localparam int PS_PSR    = 0;
   localparam int PS_CPUID  = 1;
   localparam int PS_EPSR   = 2;
   localparam int PS_EPC    = 3;
   localparam int PS_ELSA   = 4;
   localparam int PS_COREID = 5;

   // Instruction TLB bank
   localparam int IMM_TLB_SEL  = 8;
   localparam int IMM_TLBH_SEL = 7;

   localparam int IRQC_IMR = 0;
   localparam int IRQC_IRR = 1;

   localparam int TSC_TSR = 0;
   localparam int TSC_TCR = 1;

   typedef struct packed {
      logic [1:0] rsvd_hi;
      logic       dmme;
      logic       imme;
      logic       ire;
      logic       rm;
      logic [2:0] rsvd_lo;
      logic       cc;
   } psr_t;

   // Boot in kernel mode
   localparam psr_t PSR_RESET = psr_t'(10'h010);

   // Reserved bits are dropped when a word is written into a PSR
   function automatic psr_t psr_from_word(logic [31:0] w);
      psr_t p;
      p = psr_t'(w[$bits(psr_t)-1:0]);
      p.rsvd_hi = '0;
      p.rsvd_lo = '0;
      return p;
   endfunction

   // Exception entry: kernel mode, interrupts off
   function automatic psr_t psr_exp_entry(psr_t cur);
      psr_t p;
      p = cur;
      p.rm  = 1'b1;
      p.ire = 1'b0;
      return p;
   endfunction

endpackage

/* hw/msr_bus_pkg.sv */
package msr_bus_pkg;

   typedef enum logic [1:0] {
      OP_RMSR    = 2'd0,
      OP_WMSR    = 2'd1,
      OP_SYSCALL = 2'd2,
      OP_RET     = 2'd3
   } msr_op_kind_t;

   // For SYSCALL, opc carries the PC of the instruction
   typedef struct packed {
      msr_op_kind_t kind;
      logic [31:0]  opa;
      logic [31:0]  opb;
      logic [31:0]  opc;
   } msr_op_t;

   typedef struct packed {
      logic [31:0] data;
   } msr_result_t;

   localparam int APB_AW = 8;

   localparam logic [APB_AW-1:0] APB_OP_A   = 8'h00;
   localparam logic [APB_AW-1:0] APB_OP_B   = 8'h04;
   localparam logic [APB_AW-1:0] APB_OP_C   = 8'h08;
   localparam logic [APB_AW-1:0] APB_CMD    = 8'h0C;
   localparam logic [APB_AW-1:0] APB_RESULT = 8'h10;
   localparam logic [APB_AW-1:0] APB_STATUS = 8'h14;

   // Operation kind sits in the low bits of the command word
   localparam int CMD_KIND_LSB = 0;

   // STATUS layout
   localparam int STATUS_OP_FULL  = 0;
   localparam int STATUS_CNT_LSB  = 8;

endpackage

/* hw/msr_queue.sv */
`timescale 1ns/10ps

module msr_queue #(
   parameter type payload_t   = logic [31:0],
   parameter int  QUEUE_DEPTH = 4
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               push,
   input  payload_t                           push_data,
   output logic                               full,
   input  logic                               pop,
   output payload_t                           head,
   output logic                               empty,
   output logic [$clog2(QUEUE_DEPTH+1)-1:0]   count
);

   localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

   payload_t         mem [QUEUE_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;

   // Wrap explicitly so any depth works
   function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
      return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= ptr_inc(wr_ptr);
         if (pop)
            rd_ptr <= ptr_inc(rd_ptr);
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   assign full  = (count == CNT_W'(QUEUE_DEPTH));
   assign empty = (count == '0);
   assign head  = mem[rd_ptr];

   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
      else $error("msr_queue: push while full");
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
      else $error("msr_queue: pop while empty");

endmodule

/* hw/msr_apb_port.sv */
`timescale 1ns/10ps

module msr_apb_port
   import msr_bus_pkg::*;
#(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic [APB_AW-1:0]                  paddr,
   input  logic                               psel,
   input  logic                               penable,
   input  logic                               pwrite,
   input  logic [31:0]                        pwdata,
   output logic [31:0]                        prdata,
   output logic                               pready,
   output logic                               pslverr,
   output logic                               op_push,
   output msr_op_t                            op_data,
   input  logic                               op_full,
   output logic                               res_pop,
   input  msr_result_t                        res_data,
   input  logic                               res_empty,
   input  logic [$clog2(QUEUE_DEPTH+1)-1:0]   res_count
);

   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

   logic [31:0] opa_q;
   logic [31:0] opb_q;
   logic [31:0] opc_q;
   logic        acc_wr;
   logic        acc_rd;
   logic        cmd_wr;
   logic        res_rd;
   logic [31:0] status;

   assign acc_wr = psel && penable && pwrite;
   assign acc_rd = psel && penable && !pwrite;
   assign cmd_wr = acc_wr && (paddr == APB_CMD);
   assign res_rd = acc_rd && (paddr == APB_RESULT);

   // Operand staging
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         opa_q <= '0;
         opb_q <= '0;
         opc_q <= '0;
      end else if (acc_wr) begin
         if (paddr == APB_OP_A)
            opa_q <= pwdata;
         if (paddr == APB_OP_B)
            opb_q <= pwdata;
         if (paddr == APB_OP_C)
            opc_q <= pwdata;
      end
   end

   assign op_data.kind = msr_op_kind_t'(pwdata[CMD_KIND_LSB +: 2]);
   assign op_data.opa  = opa_q;
   assign op_data.opb  = opb_q;
   assign op_data.opc  = opc_q;

   // A CMD write waits here until op_q has room
   assign op_push = cmd_wr && !op_full;
   assign pready  = !(cmd_wr && op_full);

   assign res_pop = res_rd && !res_empty;
   assign pslverr = res_rd && res_empty;

   always_comb begin
      status = '0;
      status[STATUS_OP_FULL] = op_full;
      status[STATUS_CNT_LSB +: CNT_W] = res_count;
   end

   // Operand and command registers are write-only
   always_comb begin
      prdata = '0;
      if (acc_rd) begin
         case (paddr)
            APB_RESULT: prdata = res_empty ? '0 : res_data.data;
            APB_STATUS: prdata = status;
            default:    prdata = '0;
         endcase
      end
   end

   a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n) penable |-> psel)
      else $error("msr_apb_port: penable without psel");

endmodule

/* hw/msr_exec_unit.sv */
`timescale 1ns/10ps

module msr_exec_unit
   import msr_map_pkg::*;
   import msr_bus_pkg::*;
#(
   parameter int          TLB_AW  = 4,
   parameter logic [31:0] CPU_ID  = 32'h0,
   parameter logic [31:0] CORE_ID = 32'h0
) (
   input  logic              clk,
   input  logic              rst_n,
   input  msr_op_t           op_head,
   input  logic              op_empty,
   output logic              op_pop,
   input  logic              res_full,
   output logic              res_push,
   output msr_result_t       res_data,
   input  psr_t              psr,
   input  psr_t              epsr,
   input  logic [31:0]       epc,
   input  logic [31:0]       elsa,
   input  logic [31:0]       imr,
   input  logic [31:0]       irr,
   input  logic [31:0]       tsr,
   input  logic [31:0]       tcr,
   input  logic [31:0]       tlbl_rd,
   input  logic [31:0]       tlbh_rd,
   output logic [TLB_AW-1:0] tlb_idx,
   output logic              psr_we,
   output psr_t              psr_nxt,
   output logic              epsr_we,
   output psr_t              epsr_nxt,
   output logic              epc_we,
   output logic [31:0]       epc_nxt,
   output logic              elsa_we,
   output logic [31:0]       elsa_nxt,
   output logic              tlbl_we,
   output logic              tlbh_we,
   output logic              imr_we,
   output logic              tsr_we,
   output logic              tcr_we,
   output logic [31:0]       wdata
);

   localparam logic [31:0] IMM_ID = 32'(2 ** TLB_AW);

   logic [31:0]          msr_addr;
   msr_bank_t            bank;
   logic [msr_off_w-1:0] off;
   logic                 is_rmsr;
   logic                 is_wmsr;
   logic                 is_syscall;
   logic                 is_ret;
   logic                 tlbl_sel;
   logic                 tlbh_sel;
   logic [31:0]          dout_ps;
   logic [31:0]          dout_imm;
   logic [31:0]          dout_irqc;
   logic [31:0]          dout_tsc;
   logic                 wmsr_ps;
   logic                 wmsr_psr;

   // Retire one operation per cycle; a read also needs a result slot
   assign is_rmsr    = (op_head.kind == OP_RMSR);
   assign is_wmsr    = (op_head.kind == OP_WMSR);
   assign is_syscall = (op_head.kind == OP_SYSCALL);
   assign is_ret     = (op_head.kind == OP_RET);
   assign op_pop     = !op_empty && !(is_rmsr && res_full);
   assign res_push   = op_pop && is_rmsr;

   assign msr_addr = op_head.opa + op_head.opb;
   assign bank     = msr_bank_t'(msr_addr[msr_off_w +: MSR_BANK_W]);
   assign off      = msr_addr[msr_off_w-1:0];
   assign tlb_idx  = off[TLB_AW-1:0];

   assign tlbl_sel = off[IMM_TLB_SEL] && !off[IMM_TLBH_SEL];
   assign tlbh_sel = off[IMM_TLB_SEL] && off[IMM_TLBH_SEL];

   // Registers selected together are ORed
   assign dout_ps = ({32{off[PS_PSR]}}    & 32'(psr))  |
                    ({32{off[PS_CPUID]}}  & CPU_ID)    |
                    ({32{off[PS_EPSR]}}   & 32'(epsr)) |
                    ({32{off[PS_EPC]}}    & epc)       |
                    ({32{off[PS_ELSA]}}   & elsa)      |
                    ({32{off[PS_COREID]}} & CORE_ID);
   assign dout_imm = ({32{!off[IMM_TLB_SEL]}} & IMM_ID)  |
                     ({32{tlbl_sel}}          & tlbl_rd) |
                     ({32{tlbh_sel}}          & tlbh_rd);
   assign dout_irqc = ({32{off[IRQC_IMR]}} & imr) | ({32{off[IRQC_IRR]}} & irr);
   assign dout_tsc  = ({32{off[TSC_TSR]}} & tsr) | ({32{off[TSC_TCR]}} & tcr);

   always_comb begin
      case (bank)
         BANK_PS:   res_data.data = dout_ps;
         BANK_IMM:  res_data.data = dout_imm;
         BANK_IRQC: res_data.data = dout_irqc;
         BANK_TSC:  res_data.data = dout_tsc;
         default:   res_data.data = '0;
      endcase
   end

   // Write-back
   assign wdata    = op_head.opc;
   assign wmsr_ps  = op_pop && is_wmsr && (bank == BANK_PS);
   assign wmsr_psr = wmsr_ps && off[PS_PSR];

   assign psr_we  = wmsr_psr || (op_pop && (is_syscall || is_ret));
   assign psr_nxt = wmsr_psr   ? psr_from_word(wdata) :
                    is_syscall ? psr_exp_entry(psr)   : epsr;

   assign epsr_we  = (wmsr_ps && off[PS_EPSR]) || (op_pop && is_syscall);
   assign epsr_nxt = is_syscall ? psr : psr_from_word(wdata);

   // EPC after a system call points past the instruction
   assign epc_we  = (wmsr_ps && off[PS_EPC]) || (op_pop && is_syscall);
   assign epc_nxt = is_syscall ? wdata + 32'd4 : wdata;

   assign elsa_we  = wmsr_ps && off[PS_ELSA];
   assign elsa_nxt = wdata;

   assign tlbl_we = op_pop && is_wmsr && (bank == BANK_IMM) && tlbl_sel;
   assign tlbh_we = op_pop && is_wmsr && (bank == BANK_IMM) && tlbh_sel;
   assign imr_we  = op_pop && is_wmsr && (bank == BANK_IRQC) && off[IRQC_IMR];
   assign tsr_we  = op_pop && is_wmsr && (bank == BANK_TSC) && off[TSC_TSR];
   assign tcr_we  = op_pop && is_wmsr && (bank == BANK_TSC) && off[TSC_TCR];

   // The register file holds the new PSR and EPC from the next edge on
   a_psr_taken: assert property (@(posedge clk) disable iff (!rst_n)
      psr_we |=> (psr == $past(psr_nxt)))
      else $error("msr_exec_unit: PSR write not taken by the register file");
   a_epc_taken: assert property (@(posedge clk) disable iff (!rst_n)
      epc_we |=> (epc == $past(epc_nxt)))
      else $error("msr_exec_unit: EPC write not taken by the register file");

endmodule

/* hw/msr_regfile.sv */
`timescale 1ns/10ps

module msr_regfile
   import msr_map_pkg::*;
#(
   parameter int TLB_AW = 4
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic [31:0]       irq_lines,
   input  logic              psr_we,
   input  psr_t              psr_nxt,
   input  logic              epsr_we,
   input  psr_t              epsr_nxt,
   input  logic              epc_we,
   input  logic [31:0]       epc_nxt,
   input  logic              elsa_we,
   input  logic [31:0]       elsa_nxt,
   input  logic              tlbl_we,
   input  logic              tlbh_we,
   input  logic              imr_we,
   input  logic              tsr_we,
   input  logic              tcr_we,
   input  logic [31:0]       wdata,
   input  logic [TLB_AW-1:0] tlb_idx,
   output psr_t              psr,
   output psr_t              epsr,
   output logic [31:0]       epc,
   output logic [31:0]       elsa,
   output logic [31:0]       imr,
   output logic [31:0]       irr,
   output logic [31:0]       tsr,
   output logic [31:0]       tcr,
   output logic [31:0]       tlbl_rd,
   output logic [31:0]       tlbh_rd
);

   localparam int TLB_N = 2 ** TLB_AW;

   logic [31:0] tlbl_mem [TLB_N];
   logic [31:0] tlbh_mem [TLB_N];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         psr  <= PSR_RESET;
         epsr <= '0;
         epc  <= '0;
         elsa <= '0;
         imr  <= '0;
         tsr  <= '0;
         tcr  <= '0;
      end else begin
         if (psr_we)
            psr <= psr_nxt;
         if (epsr_we)
            epsr <= epsr_nxt;
         if (epc_we)
            epc <= epc_nxt;
         if (elsa_we)
            elsa <= elsa_nxt;
         if (imr_we)
            imr <= wdata;
         // TSC is plain storage, no counting
         if (tsr_we)
            tsr <= wdata;
         if (tcr_we)
            tcr <= wdata;
      end
   end

   // Pending interrupts follow the lines one cycle late
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         irr <= '0;
      else
         irr <= irq_lines;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < TLB_N; i++) begin
            tlbl_mem[i] <= '0;
            tlbh_mem[i] <= '0;
         end
      end else begin
         if (tlbl_we)
            tlbl_mem[tlb_idx] <= wdata;
         if (tlbh_we)
            tlbh_mem[tlb_idx] <= wdata;
      end
   end

   assign tlbl_rd = tlbl_mem[tlb_idx];
   assign tlbh_rd = tlbh_mem[tlb_idx];

endmodule

/* hw/msr_subsys_top.sv */
`timescale 1ns/10ps

module msr_subsys_top
   import msr_map_pkg::*;
   import msr_bus_pkg::*;
#(
   parameter int          TLB_AW      = 4,
   parameter int          QUEUE_DEPTH = 4,
   parameter logic [31:0] CPU_ID      = 32'h0,
   parameter logic [31:0] CORE_ID     = 32'h0
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic [APB_AW-1:0] paddr,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [31:0]       pwdata,
   output logic [31:0]       prdata,
   output logic              pready,
   output logic              pslverr,
   input  logic [31:0]       irq_lines
);

   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

   logic              op_push;
   msr_op_t           op_in;
   logic              op_full;
   logic              op_pop;
   msr_op_t           op_head;
   logic              op_empty;
   logic              res_push;
   msr_result_t       res_in;
   logic              res_full;
   logic              res_pop;
   msr_result_t       res_head;
   logic              res_empty;
   logic [CNT_W-1:0]  res_count;

   psr_t              psr;
   psr_t              epsr;
   psr_t              psr_nxt;
   psr_t              epsr_nxt;
   logic              psr_we;
   logic              epsr_we;
   logic              epc_we;
   logic              elsa_we;
   logic [31:0]       epc;
   logic [31:0]       elsa;
   logic [31:0]       epc_nxt;
   logic [31:0]       elsa_nxt;
   logic [31:0]       imr;
   logic [31:0]       irr;
   logic [31:0]       tsr;
   logic [31:0]       tcr;
   logic [31:0]       tlbl_rd;
   logic [31:0]       tlbh_rd;
   logic [TLB_AW-1:0] tlb_idx;
   logic              tlbl_we;
   logic              tlbh_we;
   logic              imr_we;
   logic              tsr_we;
   logic              tcr_we;
   logic [31:0]       wdata;

   msr_apb_port #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) apb_port_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .paddr     (paddr),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .op_push   (op_push),
      .op_data   (op_in),
      .op_full   (op_full),
      .res_pop   (res_pop),
      .res_data  (res_head),
      .res_empty (res_empty),
      .res_count (res_count)
   );

   // Operation occupancy is not reported, only full
   msr_queue #(
      .payload_t   (msr_op_t),
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) op_q (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (op_push),
      .push_data (op_in),
      .full      (op_full),
      .pop       (op_pop),
      .head      (op_head),
      .empty     (op_empty),
      .count     ()
   );

   msr_queue #(
      .payload_t   (msr_result_t),
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) res_q (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (res_push),
      .push_data (res_in),
      .full      (res_full),
      .pop       (res_pop),
      .head      (res_head),
      .empty     (res_empty),
      .count     (res_count)
   );

   msr_exec_unit #(
      .TLB_AW  (TLB_AW),
      .CPU_ID  (CPU_ID),
      .CORE_ID (CORE_ID)
   ) exec_unit_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .op_head  (op_head),
      .op_empty (op_empty),
      .op_pop   (op_pop),
      .res_full (res_full),
      .res_push (res_push),
      .res_data (res_in),
      .psr      (psr),
      .epsr     (epsr),
      .epc      (epc),
      .elsa     (elsa),
      .imr      (imr),
      .irr      (irr),
      .tsr      (tsr),
      .tcr      (tcr),
      .tlbl_rd  (tlbl_rd),
      .tlbh_rd  (tlbh_rd),
      .tlb_idx  (tlb_idx),
      .psr_we   (psr_we),
      .psr_nxt  (psr_nxt),
      .epsr_we  (epsr_we),
      .epsr_nxt (epsr_nxt),
      .epc_we   (epc_we),
      .epc_nxt  (epc_nxt),
      .elsa_we  (elsa_we),
      .elsa_nxt (elsa_nxt),
      .tlbl_we  (tlbl_we),
      .tlbh_we  (tlbh_we),
      .imr_we   (imr_we),
      .tsr_we   (tsr_we),
      .tcr_we   (tcr_we),
      .wdata    (wdata)
   );

   msr_regfile #(
      .TLB_AW (TLB_AW)
   ) regfile_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .irq_lines (irq_lines),
      .psr_we    (psr_we),
      .psr_nxt   (psr_nxt),
      .epsr_we   (epsr_we),
      .epsr_nxt  (epsr_nxt),
      .epc_we    (epc_we),
      .epc_nxt   (epc_nxt),
      .elsa_we   (elsa_we),
      .elsa_nxt  (elsa_nxt),
      .tlbl_we   (tlbl_we),
      .tlbh_we   (tlbh_we),
      .imr_we    (imr_we),
      .tsr_we    (tsr_we),
      .tcr_we    (tcr_we),
      .wdata     (wdata),
      .tlb_idx   (tlb_idx),
      .psr       (psr),
      .epsr      (epsr),
      .epc       (epc),
      .elsa      (elsa),
      .imr       (imr),
      .irr       (irr),
      .tsr       (tsr),
      .tcr       (tcr),
      .tlbl_rd   (tlbl_rd),
      .tlbh_rd   (tlbh_rd)
   );

endmodule

/* tests/msr_ref_model.svh */
`ifndef MSR_REF_MODEL_SVH
`define MSR_REF_MODEL_SVH

// Named PSR fields are cc, rm, ire, imme and dmme
localparam logic [9:0] PSR_KEEP = 10'h0F1;

logic [9:0]  m_psr;
logic [9:0]  m_epsr;
logic [31:0] m_epc;
logic [31:0] m_elsa;
logic [31:0] m_imr;
logic [31:0] m_irr;
logic [31:0] m_tsr;
logic [31:0] m_tcr;
logic [31:0] m_tlbl [TLB_N];
logic [31:0] m_tlbh [TLB_N];

function automatic void model_reset();
   m_psr  = 10'h010;
   m_epsr = '0;
   m_epc  = '0;
   m_elsa = '0;
   m_imr  = '0;
   m_irr  = '0;
   m_tsr  = '0;
   m_tcr  = '0;
   for (int i = 0; i < TLB_N; i++) begin
      m_tlbl[i] = '0;
      m_tlbh[i] = '0;
   end
endfunction

// Bank from address bits 11:9, selected registers ORed
function automatic logic [31:0] model_read(input logic [31:0] addr);
   logic [2:0]  bank;
   logic [8:0]  off;
   logic [31:0] v;
   bank = addr[11:9];
   off  = addr[8:0];
   v    = '0;
   case (bank)
      3'd0: begin
         if (off[0])
            v |= 32'(m_psr);
         if (off[1])
            v |= CPU_ID;
         if (off[2])
            v |= 32'(m_epsr);
         if (off[3])
            v |= m_epc;
         if (off[4])
            v |= m_elsa;
         if (off[5])
            v |= CORE_ID;
      end
      3'd1: begin
         if (!off[8])
            v = 32'(TLB_N);
         else if (off[7])
            v = m_tlbh[off[TLB_AW-1:0]];
         else
            v = m_tlbl[off[TLB_AW-1:0]];
      end
      3'd6: begin
         if (off[0])
            v |= m_imr;
         if (off[1])
            v |= m_irr;
      end
      3'd7: begin
         if (off[0])
            v |= m_tsr;
         if (off[1])
            v |= m_tcr;
      end
      default: v = '0;
   endcase
   return v;
endfunction

function automatic void model_apply(input msr_op_kind_t kind, input logic [31:0] addr,
                                    input logic [31:0] data);
   logic [2:0] bank;
   logic [8:0] off;
   bank = addr[11:9];
   off  = addr[8:0];
   case (kind)
      OP_WMSR: begin
         if (bank == 3'd0) begin
            if (off[0])
               m_psr = data[9:0] & PSR_KEEP;
            if (off[2])
               m_epsr = data[9:0] & PSR_KEEP;
            if (off[3])
               m_epc = data;
            if (off[4])
               m_elsa = data;
         end else if (bank == 3'd1 && off[8]) begin
            if (off[7])
               m_tlbh[off[TLB_AW-1:0]] = data;
            else
               m_tlbl[off[TLB_AW-1:0]] = data;
         end else if (bank == 3'd6) begin
            if (off[0])
               m_imr = data;
         end else if (bank == 3'd7) begin
            if (off[0])
               m_tsr = data;
            if (off[1])
               m_tcr = data;
         end
      end
      // Exception entry, data is the PC
      OP_SYSCALL: begin
         m_epsr = m_psr;
         m_epc  = data + 32'd4;
         m_psr  = (m_psr | 10'h010) & ~10'h020;
      end
      OP_RET: m_psr = m_epsr;
      default: ;
   endcase
endfunction

`endif

/* tests/tb_msr_subsys.sv */
`timescale 1ns/10ps

module tb_msr_subsys
   import msr_bus_pkg::*;
();

   localparam int          TLB_AW       = 4;
   localparam int          TLB_N        = 2 ** TLB_AW;
   localparam int          QUEUE_DEPTH  = 4;
   localparam logic [31:0] CPU_ID       = 32'h3200_0001;
   localparam logic [31:0] CORE_ID      = 32'h0000_0002;
   localparam int          CLK_PERIOD   = 20;
   localparam int          N_RANDOM     = 120;
   localparam int          N_TLB        = 24;
   localparam int          WATCH_OPS    = 400;
   localparam int          CYC_PER_OP   = 40;
   localparam int          XFER_WAIT    = 50;
   localparam int          STALL_WAIT   = 6;
   localparam int          RESULT_POLLS = 40;

   logic              clk;
   logic              rst_n;
   logic [APB_AW-1:0] paddr;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [31:0]       pwdata;
   logic [31:0]       prdata;
   logic              pready;
   logic              pslverr;
   logic [31:0]       irq_lines;

   int          errors = 0;
   int          checks = 0;
   logic [31:0] rng_state = 32'd27870;

   `include "msr_ref_model.svh"

   msr_subsys_top #(
      .TLB_AW      (TLB_AW),
      .QUEUE_DEPTH (QUEUE_DEPTH),
      .CPU_ID      (CPU_ID),
      .CORE_ID     (CORE_ID)
   ) dut_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .paddr     (paddr),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .irq_lines (irq_lines)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCH_OPS * CYC_PER_OP * CLK_PERIOD);
      $display("Watchdog expired, test did not finish in time (%0d errors so far)", errors);
      $display("Regression failed");
      $finish;
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Mostly mapped banks, one-hot or random offsets, random upper bits
   function automatic logic [31:0] pick_addr(input logic [31:0] r);
      logic [2:0] bank;
      logic [8:0] off;
      case (r[1:0])
         2'd0:    bank = 3'd0;
         2'd1:    bank = 3'd1;
         2'd2:    bank = 3'd6;
         default: bank = 3'd7;
      endcase
      if (r[4:2] == 3'b000)
         bank = 3'd2 + {1'b0, r[6:5]};
      if (r[7])
         off = 9'd1 << (r[10:8] % 6);
      else
         off = r[19:11];
      if (bank == 3'd1 && r[20])
         off[8] = 1'b1;
      return {r[31:21], 9'b0, bank, off};
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("[ERROR] %0t ns %s: got 0x%h, expected 0x%h", $time, name, got, exp);
      end
   endtask

   // Setup cycle, then access cycles until pready or max_wait runs out
   task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                           input logic [31:0] wd, input int max_wait,
                           output logic [31:0] rd, output logic err, output logic done);
      logic ready_s;
      int   waits;
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wd;
      @(posedge clk);
      penable <= 1'b1;
      waits   = 0;
      ready_s = 1'b0;
      while (!ready_s && waits < max_wait) begin
         @(negedge clk);
         ready_s = pready;
         rd      = prdata;
         err     = pslverr;
         @(posedge clk);
         waits++;
      end
      done = ready_s;
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] wd);
      logic [31:0] rd;
      logic        err;
      logic        done;
      apb_xfer(1'b1, addr, wd, XFER_WAIT, rd, err, done);
      assert (done) else begin
         errors++;
         $display("%0t ns: APB write to 0x%h never completed", $time, addr);
      end
   endtask

   task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] rd,
                           output logic err);
      logic done;
      apb_xfer(1'b0, addr, 32'h0, XFER_WAIT, rd, err, done);
      assert (done) else begin
         errors++;
         $display("%0t ns: APB read of 0x%h never completed", $time, addr);
      end
   endtask

   // Random split of the MSR address over opa and opb
   task automatic load_operands(input logic [31:0] addr, input logic [31:0] data);
      logic [31:0] a;
      a = next_rand();
      apb_write(APB_OP_A, a);
      apb_write(APB_OP_B, addr - a);
      apb_write(APB_OP_C, data);
   endtask

   task automatic issue_op(input msr_op_kind_t kind, input logic [31:0] addr,
                           input logic [31:0] data);
      load_operands(addr, data);
      apb_write(APB_CMD, 32'(kind));
      model_apply(kind, addr, data);
   endtask

   task automatic fetch_result(output logic [31:0] data);
      logic [31:0] st;
      logic        err;
      int          polls;
      polls = 0;
      apb_read(APB_STATUS, st, err);
      while (st[15:8] == 8'd0 && polls < RESULT_POLLS) begin
         apb_read(APB_STATUS, st, err);
         polls++;
      end
      assert (st[15:8] != 8'd0) else begin
         errors++;
         $display("%0t ns: no read result arrived while polling STATUS", $time);
      end
      apb_read(APB_RESULT, data, err);
      check_val("pslverr", 32'(err), 32'd0);
   endtask

   task automatic read_expect(input string name, input logic [31:0] addr,
                              input logic [31:0] exp);
      logic [31:0] got;
      issue_op(OP_RMSR, addr, next_rand());
      fetch_result(got);
      check_val(name, got, exp);
   endtask

   task automatic read_model(input string name, input logic [31:0] addr);
      read_expect(name, addr, model_read(addr));
   endtask

   initial begin
      logic [31:0]  r;
      logic [31:0]  addr;
      logic [31:0]  rd;
      logic [31:0]  irq_val;
      logic         err;
      logic         done;
      logic [31:0]  expect_q [$];

      rst_n     = 1'b0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      irq_lines = '0;
      model_reset();
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;

      // Reset values and identification words
      read_expect("PSR after reset", 32'h001, 32'h010);
      read_expect("CPUID", 32'h002, CPU_ID);
      read_expect("COREID", 32'h020, CORE_ID);
      read_expect("IMM ID word", 32'h200, 32'(TLB_N));
      for (int b = 2; b < 6; b++)
         read_expect("unmapped bank", {20'h0, 3'(b), 9'h1FF}, 32'h0);

      for (int n = 0; n < N_RANDOM; n++) begin
         if (n % 16 == 0) begin
            irq_val = next_rand();
            @(posedge clk);
            irq_lines <= irq_val;
            m_irr = irq_val;
         end
         r = next_rand();
         if (r[3:0] < 4'd7) begin
            addr = pick_addr(next_rand());
            issue_op(OP_WMSR, addr, next_rand());
            read_model("read after write", addr);
         end else if (r[3:0] < 4'd12) begin
            read_model("random read", pick_addr(next_rand()));
         end else if (r[3:0] < 4'd14) begin
            issue_op(OP_SYSCALL, pick_addr(next_rand()), next_rand() & ~32'h3);
            read_model("PSR after SYSCALL", 32'h001);
            read_model("EPSR after SYSCALL", 32'h004);
            read_model("EPC after SYSCALL", 32'h008);
         end else begin
            issue_op(OP_RET, pick_addr(next_rand()), next_rand());
            read_model("PSR after RET", 32'h001);
         end
      end

      // TLB arrays, bit 8 selects the TLB and bit 7 the high array
      for (int n = 0; n < N_TLB; n++) begin
         r    = next_rand();
         addr = {20'h0, 3'd1, 1'b1, r[4], 3'b0, r[3:0]};
         issue_op(OP_WMSR, addr, next_rand());
         read_model("TLB entry", addr);
         read_model("other TLB array", addr ^ 32'h080);
      end

      // Fill both queues without draining
      for (int n = 0; n < 2 * QUEUE_DEPTH; n++) begin
         addr = pick_addr(next_rand());
         expect_q.push_back(model_read(addr));
         issue_op(OP_RMSR, addr, 32'h0);
      end
      apb_read(APB_STATUS, rd, err);
      check_val("STATUS", rd, (32'(QUEUE_DEPTH) << 8) | 32'h1);
      addr = pick_addr(next_rand());
      expect_q.push_back(model_read(addr));
      load_operands(addr, 32'h0);
      apb_xfer(1'b1, APB_CMD, 32'(OP_RMSR), STALL_WAIT, rd, err, done);
      assert (!done) else begin
         errors++;
         $display("%0t ns: CMD write completed although the operation queue was full", $time);
      end
      // One drained result frees a slot for the held-back command
      fetch_result(rd);
      check_val("RESULT drained", rd, expect_q.pop_front());
      apb_write(APB_CMD, 32'(OP_RMSR));
      while (expect_q.size() > 0) begin
         fetch_result(rd);
         check_val("RESULT drained", rd, expect_q.pop_front());
      end

      apb_read(APB_RESULT, rd, err);
      check_val("pslverr on empty RESULT", 32'(err), 32'd1);
      check_val("prdata on empty RESULT", rd, 32'h0);

      irq_val = next_rand();
      @(posedge clk);
      irq_lines <= irq_val;
      m_irr = irq_val;
      read_expect("IRR", 32'h0C02, irq_val);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+tests
hw/msr_map_pkg.sv
hw/msr_bus_pkg.sv
hw/msr_queue.sv
hw/msr_apb_port.sv
hw/msr_exec_unit.sv
hw/msr_regfile.sv
hw/msr_subsys_top.sv
tests/tb_msr_subsys.sv
